/* rv_pkg.sv */
package rv_pkg;

  // data and address width
  localparam int xlen = 32;

  // major opcodes handled by the unit
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 of register and immediate arithmetic
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 of conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // jalr only exists with funct3 zero
  localparam logic [2:0] f3_jalr = 3'b000;

  // funct7 variants, alt selects sub and sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // the two supported system words
  localparam logic [xlen-1:0] instr_ecall  = 32'h0000_0073;
  localparam logic [xlen-1:0] instr_ebreak = 32'h0010_0073;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_none,
    wb_alu,
    wb_link
  } wb_sel_t;

  typedef enum logic [1:0] {
    pc_next,
    pc_jump,
    pc_cond
  } pc_sel_t;

  // s, b, u and j immediates are put together from the r view
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_word_t;

endpackage

/* instr_decoder.sv */
module instr_decoder import rv_pkg::*; (
  input  logic [xlen-1:0] instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output alu_op_t         alu_op,
  output logic [xlen-1:0] op1,
  output logic [xlen-1:0] op2,
  output wb_sel_t         wb_sel,
  output pc_sel_t         pc_sel,
  output logic [xlen-1:0] jump_target,
  output logic [xlen-1:0] pc_plus_4,
  output logic [4:0]      rd_addr,
  output logic            illegal,
  output logic            env_call,
  output logic            break_point
);

  instr_word_t     iw;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            f7_is_alt;
  logic            f7_is_base;
  wb_sel_t         wb_cand;

  // funct3 to arithmetic op, alt picks sub / sra
  function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    case (funct3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
    endcase
    return op;
  endfunction

  assign iw.raw = instr;

  assign f7_is_alt  = iw.r.funct7 == f7_alt;
  assign f7_is_base = iw.r.funct7 == f7_base;

  // sign-extended immediates
  assign imm_i = {{20{iw.i.imm[11]}}, iw.i.imm};
  assign imm_b = {{20{iw.r.funct7[6]}}, iw.r.rd[0], iw.r.funct7[5:0], iw.r.rd[4:1], 1'b0};
  assign imm_u = {iw.r.funct7, iw.r.rs2, iw.r.rs1, iw.r.funct3, 12'h000};
  assign imm_j = {{12{iw.r.funct7[6]}}, iw.r.rs1, iw.r.funct3, iw.r.rs2[0],
                  iw.r.funct7[5:0], iw.r.rs2[4:1], 1'b0};

  assign pc_plus_4 = pc + 32'd4;
  assign rd_addr   = iw.r.rd;

  always_comb begin
    alu_op      = alu_add;
    op1         = rs1_data;
    op2         = rs2_data;
    wb_cand     = wb_none;
    pc_sel      = pc_next;
    jump_target = pc_plus_4;
    illegal     = 1'b0;
    env_call    = 1'b0;
    break_point = 1'b0;

    case (iw.r.opcode)
      opc_op: begin
        wb_cand = wb_alu;
        alu_op  = arith_op(iw.r.funct3, f7_is_alt);
        // only add and sr have an alternate form
        illegal = !(f7_is_base || (f7_is_alt && (iw.r.funct3 == f3_add ||
                                                 iw.r.funct3 == f3_sr)));
      end
      opc_op_imm: begin
        wb_cand = wb_alu;
        op2     = imm_i;
        // imm[10] marks srai, addi never becomes sub
        alu_op  = arith_op(iw.i.funct3, iw.i.funct3 == f3_sr && f7_is_alt);
        if (iw.i.funct3 == f3_sll) begin
          illegal = !f7_is_base;
        end else if (iw.i.funct3 == f3_sr) begin
          illegal = !(f7_is_base || f7_is_alt);
        end
      end
      opc_lui: begin
        wb_cand = wb_alu;
        op1     = imm_u;
        op2     = '0;
      end
      opc_auipc: begin
        wb_cand = wb_alu;
        op1     = imm_u;
        op2     = pc;
      end
      opc_jal: begin
        wb_cand     = wb_link;
        pc_sel      = pc_jump;
        jump_target = pc + imm_j;
      end
      opc_jalr: begin
        wb_cand        = wb_link;
        pc_sel         = pc_jump;
        jump_target    = rs1_data + imm_i;
        jump_target[0] = 1'b0;
        illegal        = iw.i.funct3 != f3_jalr;
      end
      opc_branch: begin
        pc_sel      = pc_cond;
        jump_target = pc + imm_b;
        case (iw.r.funct3)
          f3_beq:  alu_op = alu_eq;
          f3_bne:  alu_op = alu_ne;
          f3_blt:  alu_op = alu_lt;
          f3_bge:  alu_op = alu_ge;
          f3_bltu: alu_op = alu_ltu;
          f3_bgeu: alu_op = alu_geu;
          default: illegal = 1'b1;
        endcase
      end
      opc_system: begin
        // csr access and mret fall through as illegal
        env_call    = iw.raw == instr_ecall;
        break_point = iw.raw == instr_ebreak;
        illegal     = !(env_call || break_point);
      end
      // loads, stores, fence and anything unknown
      default: illegal = 1'b1;
    endcase

    // traps never write back or redirect
    if (illegal || env_call || break_point) begin
      wb_cand = wb_none;
      pc_sel  = pc_next;
    end

    wb_sel = (iw.r.rd == 5'd0) ? wb_none : wb_cand;
  end

endmodule

/* alu_exec.sv */
module alu_exec import rv_pkg::*; (
  input  alu_op_t         alu_op,
  input  logic [xlen-1:0] op1,
  input  logic [xlen-1:0] op2,
  output logic [xlen-1:0] alu_result,
  output logic            cond_true
);

  logic [4:0] shamt;
  logic       equal;
  logic       signed_lt;
  logic       unsigned_lt;

  // shifts only look at the low five bits
  assign shamt = op2[4:0];

  // shared by slt/sltu and the branch compares
  assign equal       = op1 == op2;
  assign signed_lt   = $signed(op1) < $signed(op2);
  assign unsigned_lt = op1 < op2;

  always_comb begin
    alu_result = '0;
    cond_true  = 1'b0;

    unique case (alu_op)
      alu_add:  alu_result = op1 + op2;
      alu_sub:  alu_result = op1 - op2;
      alu_sll:  alu_result = op1 << shamt;
      alu_slt:  alu_result = xlen'(signed_lt);
      alu_sltu: alu_result = xlen'(unsigned_lt);
      alu_xor:  alu_result = op1 ^ op2;
      alu_srl:  alu_result = op1 >> shamt;
      // arithmetic shift keeps the sign bit
      alu_sra:  alu_result = $signed(op1) >>> shamt;
      alu_or:   alu_result = op1 | op2;
      alu_and:  alu_result = op1 & op2;

      // branch compares, result word stays zero
      alu_eq:   cond_true = equal;
      alu_ne:   cond_true = !equal;
      alu_lt:   cond_true = signed_lt;
      alu_ge:   cond_true = !signed_lt;
      alu_ltu:  cond_true = unsigned_lt;
      alu_geu:  cond_true = !unsigned_lt;
    endcase
  end

endmodule

/* result_stage.sv */
module result_stage import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  input  wb_sel_t         wb_sel,
  input  pc_sel_t         pc_sel,
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] jump_target,
  input  logic [xlen-1:0] pc_plus_4,
  input  logic            cond_true,
  input  logic            illegal,
  input  logic            env_call,
  input  logic            break_point,
  input  logic [4:0]      rd_addr_in,
  output logic            ack,
  output logic            rd_we,
  output logic [4:0]      rd_addr,
  output logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] next_pc,
  output logic            illegal_out,
  output logic            env_call_out,
  output logic            break_point_out
);

  // set for the cycle between seeing req change and moving ack
  logic            pend;
  logic            take;
  logic            taken;
  logic [xlen-1:0] wb_value;

  // new request, idle and nothing pending
  assign take = req && !ack && !pend;

  assign wb_value = (wb_sel == wb_link) ? pc_plus_4 : alu_result;

  always_comb begin
    case (pc_sel)
      pc_jump: taken = 1'b1;
      pc_cond: taken = cond_true;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack             <= 1'b0;
      pend            <= 1'b0;
      rd_we           <= 1'b0;
      illegal_out     <= 1'b0;
      env_call_out    <= 1'b0;
      break_point_out <= 1'b0;
    end else if (take) begin
      pend            <= 1'b1;
      rd_we           <= wb_sel != wb_none;
      illegal_out     <= illegal;
      env_call_out    <= env_call;
      break_point_out <= break_point;
    end else if (pend) begin
      // second phase, ack follows req one cycle late
      pend <= 1'b0;
      ack  <= !ack;
    end else if (ack && !req) begin
      pend <= 1'b1;
    end
  end

  // payload only moves when a request is taken
  always_ff @(posedge clk) begin
    if (take) begin
      rd_addr <= rd_addr_in;
      rd_data <= wb_value;
      next_pc <= taken ? jump_target : pc_plus_4;
    end
  end

endmodule

/* exec_unit.sv */
module exec_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,
  input  logic [xlen-1:0] instr,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic            ack,
  output logic            rd_we,
  output logic [4:0]      rd_addr,
  output logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] next_pc,
  output logic            illegal,
  output logic            env_call,
  output logic            break_point
);

  alu_op_t         alu_op;
  wb_sel_t         wb_sel;
  pc_sel_t         pc_sel;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] jump_target;
  logic [xlen-1:0] pc_plus_4;
  logic [4:0]      dec_rd_addr;
  logic            cond_true;
  logic            dec_illegal;
  logic            dec_env_call;
  logic            dec_break_point;

  // decode and execute settle within the request cycle
  instr_decoder u_decoder (
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_op      (alu_op),
    .op1         (op1),
    .op2         (op2),
    .wb_sel      (wb_sel),
    .pc_sel      (pc_sel),
    .jump_target (jump_target),
    .pc_plus_4   (pc_plus_4),
    .rd_addr     (dec_rd_addr),
    .illegal     (dec_illegal),
    .env_call    (dec_env_call),
    .break_point (dec_break_point)
  );

  alu_exec u_alu (
    .alu_op     (alu_op),
    .op1        (op1),
    .op2        (op2),
    .alu_result (alu_result),
    .cond_true  (cond_true)
  );

  result_stage u_result (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .wb_sel          (wb_sel),
    .pc_sel          (pc_sel),
    .alu_result      (alu_result),
    .jump_target     (jump_target),
    .pc_plus_4       (pc_plus_4),
    .cond_true       (cond_true),
    .illegal         (dec_illegal),
    .env_call        (dec_env_call),
    .break_point     (dec_break_point),
    .rd_addr_in      (dec_rd_addr),
    .ack             (ack),
    .rd_we           (rd_we),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .next_pc         (next_pc),
    .illegal_out     (illegal),
    .env_call_out    (env_call),
    .break_point_out (break_point)
  );

endmodule

/* exec_unit_asserts.sv */
module exec_unit_asserts import rv_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            req,
  input logic            ack,
  input logic            rd_we,
  input logic [4:0]      rd_addr,
  input logic [xlen-1:0] rd_data,
  input logic [xlen-1:0] next_pc,
  input logic            illegal,
  input logic            env_call,
  input logic            break_point
);

  int failures = 0;

  // ack drops only once req has been low for an edge
  ack_falls_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> !req && $past(!req))
    else begin
      failures++;
      $error("ack fell while req was still high");
    end

  // results hold while ack is high
  results_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(rd_we) && $stable(rd_addr) && $stable(rd_data) &&
                          $stable(next_pc) && $stable(illegal) && $stable(env_call) &&
                          $stable(break_point))
    else begin
      failures++;
      $error("result outputs changed while ack was high");
    end

  // a trap never writes a register
  no_write_on_trap: assert property (@(posedge clk) disable iff (!rst_n)
    rd_we |-> !(illegal || env_call || break_point))
    else begin
      failures++;
      $error("rd_we was high together with a trap flag");
    end

endmodule

bind exec_unit exec_unit_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .ack         (ack),
  .rd_we       (rd_we),
  .rd_addr     (rd_addr),
  .rd_data     (rd_data),
  .next_pc     (next_pc),
  .illegal     (illegal),
  .env_call    (env_call),
  .break_point (break_point)
);

/* tb_exec_unit.sv */
module tb_exec_unit import rv_pkg::*; ();

  logic            clk;
  logic            rst_n;
  logic            req;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic            ack;
  logic            rd_we;
  logic [4:0]      rd_addr;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] next_pc;
  logic            illegal;
  logic            env_call;
  logic            break_point;

  int fd;
  int vec_count;

  exec_unit u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ack         (ack),
    .rd_we       (rd_we),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .next_pc     (next_pc),
    .illegal     (illegal),
    .env_call    (env_call),
    .break_point (break_point)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic check_word(input string field, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, field, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(input string field, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, field, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string field, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, field, got, exp);
      stop_with_failure();
    end
  endtask

  // ack sampled on the falling edge away from register updates
  task automatic wait_for_ack(input logic level);
    int cycles;
    cycles = 0;
    while (ack !== level && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== level) begin
      $display("ack did not go %s within 50 cycles", level ? "high" : "low");
      stop_with_failure();
    end
  endtask

  // one full four-phase transfer and its result checks
  task automatic run_vector(input logic [xlen-1:0] v_instr, input logic [xlen-1:0] v_pc,
                            input logic [xlen-1:0] v_rs1, input logic [xlen-1:0] v_rs2,
                            input logic e_we, input logic [4:0] e_rd,
                            input logic [xlen-1:0] e_data, input logic [xlen-1:0] e_npc,
                            input logic e_ill, input logic e_ecall, input logic e_ebrk);
    @(posedge clk);
    #1;
    instr    = v_instr;
    pc       = v_pc;
    rs1_data = v_rs1;
    rs2_data = v_rs2;
    req      = 1'b1;
    wait_for_ack(1'b1);
    check_flag("rd_we", rd_we, e_we);
    // rd_addr and rd_data only matter for a real write
    if (e_we) begin
      check_reg("rd_addr", rd_addr, e_rd);
      check_word("rd_data", rd_data, e_data);
    end
    check_word("next_pc", next_pc, e_npc);
    check_flag("illegal", illegal, e_ill);
    check_flag("env_call", env_call, e_ecall);
    check_flag("break_point", break_point, e_ebrk);
    @(posedge clk);
    #1;
    req = 1'b0;
    wait_for_ack(1'b0);
  endtask

  // poll the bound checker's failure count
  always @(negedge clk) begin
    if (u_dut.u_asserts.failures != 0) begin
      $display("a handshake or output assertion on the DUT failed");
      stop_with_failure();
    end
  end

  initial begin
    string           line;
    int              n;
    logic [xlen-1:0] g_instr;
    logic [xlen-1:0] g_pc;
    logic [xlen-1:0] g_rs1;
    logic [xlen-1:0] g_rs2;
    logic            g_we;
    logic [4:0]      g_rd;
    logic [xlen-1:0] g_data;
    logic [xlen-1:0] g_npc;
    logic            g_ill;
    logic            g_ecall;
    logic            g_ebrk;

    rst_n     = 1'b0;
    req       = 1'b0;
    instr     = '0;
    pc        = '0;
    rs1_data  = '0;
    rs2_data  = '0;
    vec_count = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // outputs idle before any request
    @(negedge clk);
    check_flag("ack", ack, 1'b0);
    check_flag("rd_we", rd_we, 1'b0);
    check_flag("illegal", illegal, 1'b0);
    check_flag("env_call", env_call, 1'b0);
    check_flag("break_point", break_point, 1'b0);

    fd = $fopen("golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open golden_vectors.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", g_instr, g_pc, g_rs1, g_rs2,
                    g_we, g_rd, g_data, g_npc, g_ill, g_ecall, g_ebrk);
        if (n != 11) begin
          $display("golden_vectors.txt has a malformed record: %s", line);
          stop_with_failure();
        end
        run_vector(g_instr, g_pc, g_rs1, g_rs2, g_we, g_rd, g_data, g_npc,
                   g_ill, g_ecall, g_ebrk);
        vec_count++;
      end
    end
    $fclose(fd);

    // the last ack fall is only seen by the checker a few edges later
    repeat (2) @(posedge clk);
    #1;

    if (vec_count == 0) begin
      $display("golden_vectors.txt held no records");
      stop_with_failure();
    end else if (u_dut.u_asserts.failures != 0) begin
      $display("a handshake or output assertion on the DUT failed");
      stop_with_failure();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* golden_vectors.txt */
// instr pc rs1_data rs2_data | rd_we rd_addr rd_data next_pc illegal env_call break_point
// all hex, rd_addr and rd_data are zero where rd_we is low and are not compared
002081b3 00001000 00000005 00000007 1 03 0000000c 00001004 0 0 0 // add
402081b3 00001000 00000005 00000007 1 03 fffffffe 00001004 0 0 0 // sub
002091b3 00001000 00000001 00000024 1 03 00000010 00001004 0 0 0 // sll, low 5 bits
0020a1b3 00001000 ffffffff 00000001 1 03 00000001 00001004 0 0 0 // slt
0020b1b3 00001000 ffffffff 00000001 1 03 00000000 00001004 0 0 0 // sltu
0020c1b3 00001000 f0f0f0f0 0ff00ff0 1 03 ff00ff00 00001004 0 0 0 // xor
0020d1b3 00001000 80000000 00000004 1 03 08000000 00001004 0 0 0 // srl
4020d1b3 00001000 80000000 00000004 1 03 f8000000 00001004 0 0 0 // sra
0020e1b3 00001000 0000f000 000000f0 1 03 0000f0f0 00001004 0 0 0 // or
0020f1b3 00001000 ff00ff00 0ff00ff0 1 03 0f000f00 00001004 0 0 0 // and
fff08193 00001000 00000010 00000000 1 03 0000000f 00001004 0 0 0 // addi -1
0050a193 00001000 fffffffd 00000000 1 03 00000001 00001004 0 0 0 // slti
fff0b193 00001000 00000005 00000000 1 03 00000001 00001004 0 0 0 // sltiu
fff0c193 00001000 12345678 00000000 1 03 edcba987 00001004 0 0 0 // xori
0f00e193 00001000 00000f00 00000000 1 03 00000ff0 00001004 0 0 0 // ori
0ff0f193 00001000 12345678 00000000 1 03 00000078 00001004 0 0 0 // andi
00809193 00001000 00000012 00000000 1 03 00001200 00001004 0 0 0 // slli
0040d193 00001000 f0000000 00000000 1 03 0f000000 00001004 0 0 0 // srli
4040d193 00001000 f0000000 00000000 1 03 ff000000 00001004 0 0 0 // srai
123451b7 00001000 00000000 00000000 1 03 12345000 00001004 0 0 0 // lui
fffff197 00002000 00000000 00000000 1 03 00001000 00002004 0 0 0 // auipc
00208863 00001000 00000055 00000055 0 00 00000000 00001010 0 0 0 // beq taken
00208863 00001000 00000001 00000002 0 00 00000000 00001004 0 0 0 // beq not taken
fe209ce3 00001000 00000001 00000002 0 00 00000000 00000ff8 0 0 0 // bne taken back
fe209ce3 00001000 00000007 00000007 0 00 00000000 00001004 0 0 0 // bne not taken
0020c863 00001000 ffffffff 00000001 0 00 00000000 00001010 0 0 0 // blt taken
0020c863 00001000 00000001 ffffffff 0 00 00000000 00001004 0 0 0 // blt not taken
0020d863 00001000 00000003 00000003 0 00 00000000 00001010 0 0 0 // bge equal
0020d863 00001000 ffffffff 00000001 0 00 00000000 00001004 0 0 0 // bge not taken
0020e863 00001000 00000001 ffffffff 0 00 00000000 00001010 0 0 0 // bltu taken
0020e863 00001000 ffffffff 00000001 0 00 00000000 00001004 0 0 0 // bltu not taken
0020f863 00001000 ffffffff 00000001 0 00 00000000 00001010 0 0 0 // bgeu taken
0020f863 00001000 00000001 ffffffff 0 00 00000000 00001004 0 0 0 // bgeu not taken
100000ef 00001000 00000000 00000000 1 01 00001004 00001100 0 0 0 // jal x1
ffdff06f 00002000 00000000 00000000 0 00 00000000 00001ffc 0 0 0 // jal x0 back
003082e7 00001000 00004000 00000000 1 05 00001004 00004002 0 0 0 // jalr, bit 0 cleared
00008067 00001000 00003000 00000000 0 00 00000000 00003000 0 0 0 // jalr x0
0000a183 00001000 00000000 00000000 0 00 00000000 00001004 1 0 0 // lw
300091f3 00001000 00000000 00000000 0 00 00000000 00001004 1 0 0 // csrrw
00000000 00001000 00000000 00000000 0 00 00000000 00001004 1 0 0 // all zero
00000073 00001000 00000000 00000000 0 00 00000000 00001004 0 1 0 // ecall
00100073 00001000 00000000 00000000 0 00 00000000 00001004 0 0 1 // ebreak

/* filelist.f */
rv_pkg.sv
instr_decoder.sv
alu_exec.sv
result_stage.sv
exec_unit.sv
exec_unit_asserts.sv
tb_exec_unit.sv
